// File: files.f
hw/snes_mem_pkg.sv
hw/bus_strobe_sync.sv
hw/lorom_mapper.sv
hw/psram_sequencer.sv
hw/psram_lane_mux.sv
hw/snes_mem_top.sv
verif/psram_model.sv
verif/tb_snes_mem.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then scan the log for the failure line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_snes_mem -f files.f \
  -o tb_snes_mem > build.log 2>&1 \
  && ./obj_dir/tb_snes_mem > sim.log 2>&1 \
  || { echo "Build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "test failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

// File: verif/tb_snes_mem.sv
`timescale 1ns/1ps

module tb_snes_mem;

  localparam logic [23:0] saveram_base = 24'hE00000;
  localparam int rd_wait   = 4;
  localparam int wr_wait1  = 2;
  localparam int wr_wait2  = 3;
  localparam int mcu_wait  = 6;
  localparam int n_rom_rd  = 12;
  localparam int n_wr      = 10;
  localparam int n_round   = 8;
  localparam int n_preempt = 24;
  localparam int n_bus     = 40;
  localparam int n_trans   = n_rom_rd + 2 * n_wr + 2 * n_round + 4 * n_preempt + n_bus;

  logic                     CLK2;
  logic                     rst_n;
  logic [23:0]              snes_addr;
  logic                     snes_rd_n;
  logic                     snes_wr_n;
  logic                     snes_cs_n;
  logic                     snes_cpu_clk;
  logic [7:0]               snes_wdata;
  logic [23:0]              rom_mask;
  logic [23:0]              saveram_mask;
  snes_mem_pkg::mcu_req_t   mcu;
  logic [15:0]              psram_rdata;
  logic [7:0]               snes_rdata;
  logic                     snes_data_oe_n;
  logic                     snes_data_dir;
  logic                     mcu_rdy;
  logic [7:0]               mcu_rdata;
  snes_mem_pkg::psram_bus_t psram;

  integer      seed;
  int          checks;
  int          errors;
  logic [7:0]  ref_mem [int];
  logic        rom_wr_active;
  logic        mcu_wr_active;
  logic [23:0] mcu_wr_addr;
  logic        preempt_done;
  logic [23:0] pool [8];

  snes_mem_top #(
    .SAVERAM_BASE(saveram_base),
    .RD_WAIT     (rd_wait),
    .WR_WAIT1    (wr_wait1),
    .WR_WAIT2    (wr_wait2),
    .MCU_WAIT    (mcu_wait)
  ) dut (
    .CLK2          (CLK2),
    .rst_n         (rst_n),
    .snes_addr     (snes_addr),
    .snes_rd_n     (snes_rd_n),
    .snes_wr_n     (snes_wr_n),
    .snes_cs_n     (snes_cs_n),
    .snes_cpu_clk  (snes_cpu_clk),
    .snes_wdata    (snes_wdata),
    .rom_mask      (rom_mask),
    .saveram_mask  (saveram_mask),
    .mcu           (mcu),
    .psram_rdata   (psram_rdata),
    .snes_rdata    (snes_rdata),
    .snes_data_oe_n(snes_data_oe_n),
    .snes_data_dir (snes_data_dir),
    .mcu_rdy       (mcu_rdy),
    .mcu_rdata     (mcu_rdata),
    .psram         (psram)
  );

  psram_model u_psram (
    .CLK2 (CLK2),
    .bus  (psram),
    .rdata(psram_rdata)
  );

  initial begin
    CLK2 = 1'b0;
    forever #4 CLK2 = ~CLK2;
  end

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  function automatic int pick(input int span);
    return int'($unsigned($random(seed)) % span);
  endfunction

  function automatic logic [7:0] init_byte(input logic [23:0] b);
    logic [22:0] w;
    logic [15:0] word;
    w    = b[23:1];
    word = w[15:0] ^ {w[22:16], 9'h000} ^ 16'h5A3C;
    return b[0] ? word[7:0] : word[15:8];
  endfunction

  function automatic logic [7:0] expected_byte(input logic [23:0] b);
    if (ref_mem.exists(int'(b))) begin
      return ref_mem[int'(b)];
    end
    return init_byte(b);
  endfunction

  function automatic logic is_saveram(input logic [23:0] a);
    return (a[23:16] >= 8'h70) && (a[23:16] <= 8'h7D) && !a[15];
  endfunction

  // LoROM rule: save RAM first, then upper half of any bank
  function automatic logic [23:0] mapped_addr(input logic [23:0] a);
    if (is_saveram(a)) begin
      return saveram_base + (a & saveram_mask);
    end
    if (a[15]) begin
      return {2'b00, a[22:16], a[14:0]} & rom_mask;
    end
    return 24'h000000;
  endfunction

  function automatic logic [23:0] rom_address();
    logic [23:0] a;
    a     = 24'($random(seed));
    a[15] = 1'b1;
    return a;
  endfunction

  function automatic logic [23:0] saveram_address();
    logic [23:0] a;
    a         = 24'($random(seed));
    a[23:16]  = 8'h70 + 8'(pick(14));
    a[15]     = 1'b0;
    return a;
  endfunction

  ////////////////////////////////////////
  // Checks and bus drivers
  ////////////////////////////////////////

  task automatic compare(input string name, input logic [23:0] got, input logic [23:0] exp);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic console_read(input logic [23:0] a, input int hold, input int idle,
                              output logic [7:0] d);
    @(negedge CLK2);
    snes_addr    = a;
    snes_rd_n    = 1'b0;
    snes_cpu_clk = 1'b1;
    repeat (hold) @(negedge CLK2);
    d            = snes_rdata;
    snes_rd_n    = 1'b1;
    snes_cpu_clk = 1'b0;
    repeat (idle) @(negedge CLK2);
  endtask

  task automatic console_write(input logic [23:0] a, input logic [7:0] d);
    @(negedge CLK2);
    snes_addr    = a;
    snes_wdata   = d;
    snes_wr_n    = 1'b0;
    snes_cpu_clk = 1'b1;
    repeat (20) @(negedge CLK2);
    snes_wr_n    = 1'b1;
    snes_cpu_clk = 1'b0;
    repeat (8) @(negedge CLK2);
  endtask

  task automatic mcu_op(input logic rd, input logic [23:0] a, input logic [7:0] d,
                        input int limit);
    int n;
    @(negedge CLK2);
    mcu.rrq   = rd;
    mcu.wrq   = !rd;
    mcu.addr  = a;
    mcu.wdata = d;
    @(negedge CLK2);
    compare("mcu_rdy", 24'(mcu_rdy), 24'h0);
    mcu.rrq = 1'b0;
    mcu.wrq = 1'b0;
    n = 0;
    while (!mcu_rdy && n < limit) begin
      @(negedge CLK2);
      n++;
    end
    if (!mcu_rdy) begin
      errors++;
      $display("mcu_rdy stayed low for %0d cycles after a request to address %h", limit, a);
    end
  endtask

  // Mid-cycle sampling, away from both clock edges
  always @(posedge CLK2) begin
    #2;
    if (rst_n) begin
      compare("snes_data_dir", 24'(snes_data_dir), 24'(!snes_rd_n));
      if (rom_wr_active) begin
        compare("psram.we_n", 24'(psram.we_n), 24'h1);
        compare("psram.wdata_en", 24'(psram.wdata_en), 24'h0);
      end
      if (mcu_wr_active && !psram.we_n) begin
        compare("psram.bhe_n", 24'(psram.bhe_n), 24'(mcu_wr_addr[0]));
        compare("psram.ble_n", 24'(psram.ble_n), 24'(!mcu_wr_addr[0]));
        compare("psram.addr", 24'(psram.addr), 24'(mcu_wr_addr[23:1]));
        compare("psram.wdata_en", 24'(psram.wdata_en), 24'h1);
      end
    end
  end

  initial begin
    #(n_trans * 40 * 8);
    $display("Watchdog expired, run exceeded %0d transactions of time", n_trans);
    $display("Summary: %0d checks, %0d errors", checks, errors);
    $display("test failed");
    $finish;
  end

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    logic [23:0] a;
    logic [23:0] m;
    logic [7:0]  d;
    logic [7:0]  got;
    logic        oe_exp;
    int          k;
    seed          = 98650;
    checks        = 0;
    errors        = 0;
    rst_n         = 1'b0;
    snes_addr     = 24'h000000;
    snes_rd_n     = 1'b1;
    snes_wr_n     = 1'b1;
    snes_cs_n     = 1'b0;
    snes_cpu_clk  = 1'b0;
    snes_wdata    = 8'h00;
    rom_mask      = 24'hFFFFFF;
    saveram_mask  = 24'h00FFFF;
    mcu           = '0;
    rom_wr_active = 1'b0;
    mcu_wr_active = 1'b0;
    mcu_wr_addr   = 24'h000000;
    preempt_done  = 1'b0;
    repeat (3) @(posedge CLK2);
    @(negedge CLK2);
    rst_n = 1'b1;
    repeat (8) @(negedge CLK2);

    compare("mcu_rdy", 24'(mcu_rdy), 24'h1);
    compare("psram.we_n", 24'(psram.we_n), 24'h1);
    compare("psram.wdata_en", 24'(psram.wdata_en), 24'h0);
    compare("snes_data_oe_n", 24'(snes_data_oe_n), 24'h1);

    // Console ROM reads
    for (int i = 0; i < n_rom_rd; i++) begin
      rom_mask = 24'($random(seed));
      a        = rom_address();
      console_read(a, 16, 8, got);
      compare("snes_rdata", 24'(got), 24'(expected_byte(mapped_addr(a))));
    end

    // Console writes, save RAM then ROM, each read back
    saveram_mask = 24'($random(seed)) & 24'h01FFFF;
    for (int i = 0; i < n_wr; i++) begin
      a             = (i >= 6) ? rom_address() : saveram_address();
      d             = 8'($random(seed));
      m             = mapped_addr(a);
      rom_wr_active = (i >= 6);
      console_write(a, d);
      rom_wr_active = 1'b0;
      if (i < 6) begin
        ref_mem[int'(m)] = d;
      end
      console_read(a, 16, 8, got);
      compare("snes_rdata", 24'(got), 24'(expected_byte(m)));
    end

    // Microcontroller write then read back
    for (int i = 0; i < n_round; i++) begin
      a             = 24'($random(seed));
      d             = 8'($random(seed));
      mcu_wr_addr   = a;
      mcu_wr_active = 1'b1;
      mcu_op(1'b0, a, d, mcu_wait + 8);
      mcu_wr_active = 1'b0;
      ref_mem[int'(a)] = d;
      mcu_op(1'b1, a, 8'h00, mcu_wait + 8);
      compare("mcu_rdata", 24'(mcu_rdata), 24'(expected_byte(a)));
    end

    // Requests racing console cycles
    for (int i = 0; i < 8; i++) begin
      pool[i] = 24'($random(seed));
    end
    fork
      begin
        while (!preempt_done) begin
          console_read(rom_address(), 6 + pick(8), 6 + pick(20), got);
        end
      end
      begin
        for (int i = 0; i < n_preempt; i++) begin
          k = pick(8);
          if (pick(2) == 0) begin
            d = 8'($random(seed));
            mcu_op(1'b0, pool[k], d, 400);
            ref_mem[int'(pool[k])] = d;
          end else begin
            mcu_op(1'b1, pool[k], 8'h00, 400);
            compare("mcu_rdata", 24'(mcu_rdata), 24'(expected_byte(pool[k])));
          end
        end
        preempt_done = 1'b1;
      end
    join

    // Data bus buffer controls, memory no longer tracked
    for (int i = 0; i < n_bus; i++) begin
      a = (pick(3) == 0) ? saveram_address() : 24'($random(seed));
      @(negedge CLK2);
      snes_addr = a;
      snes_rd_n = 1'(pick(2));
      snes_wr_n = 1'(pick(2));
      snes_cs_n = 1'(pick(2));
      oe_exp    = (snes_rd_n & snes_wr_n) | (a[15] & snes_cs_n) |
                  (!a[15] & !is_saveram(a));
      @(negedge CLK2);
      compare("snes_data_oe_n", 24'(snes_data_oe_n), 24'(oe_exp));
    end

    @(negedge CLK2);
    snes_rd_n = 1'b1;
    snes_wr_n = 1'b1;
    repeat (4) @(negedge CLK2);
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: verif/psram_model.sv
`timescale 1ns/1ps

module psram_model (
  input  logic                     CLK2,
  input  snes_mem_pkg::psram_bus_t bus,
  output logic [15:0]              rdata
);

  logic [15:0] mem [0:(1<<23)-1];

  // Power-up pattern built from every address bit
  function automatic logic [15:0] fill_word(input logic [22:0] a);
    return a[15:0] ^ {a[22:16], 9'h000} ^ 16'h5A3C;
  endfunction

  initial begin
    for (int i = 0; i < (1 << 23); i++) begin
      mem[i] = fill_word(23'(i));
    end
  end

  // Even byte in the high lane, odd byte in the low lane
  always @(posedge CLK2) begin
    if (!bus.we_n) begin
      if (!bus.bhe_n) begin
        mem[bus.addr][15:8] <= bus.wdata[15:8];
      end
      if (!bus.ble_n) begin
        mem[bus.addr][7:0] <= bus.wdata[7:0];
      end
    end
  end

  assign rdata = mem[bus.addr];

endmodule

// File: hw/snes_mem_top.sv
`timescale 1ns/1ps

module snes_mem_top #(
  parameter logic [snes_mem_pkg::snes_addr_w-1:0] SAVERAM_BASE = 24'hE00000,
  parameter int RD_WAIT  = 4,
  parameter int WR_WAIT1 = 2,
  parameter int WR_WAIT2 = 3,
  parameter int MCU_WAIT = 6
) (
  input  logic                                 CLK2,
  input  logic                                 rst_n,
  input  logic [snes_mem_pkg::snes_addr_w-1:0] snes_addr,
  input  logic                                 snes_rd_n,
  input  logic                                 snes_wr_n,
  input  logic                                 snes_cs_n,
  input  logic                                 snes_cpu_clk,
  input  logic [snes_mem_pkg::data_w-1:0]      snes_wdata,
  input  logic [snes_mem_pkg::snes_addr_w-1:0] rom_mask,
  input  logic [snes_mem_pkg::snes_addr_w-1:0] saveram_mask,
  input  snes_mem_pkg::mcu_req_t               mcu,
  input  logic [2*snes_mem_pkg::data_w-1:0]    psram_rdata,
  output logic [snes_mem_pkg::data_w-1:0]      snes_rdata,
  output logic                                 snes_data_oe_n,
  output logic                                 snes_data_dir,
  output logic                                 mcu_rdy,
  output logic [snes_mem_pkg::data_w-1:0]      mcu_rdata,
  output snes_mem_pkg::psram_bus_t             psram
);

  snes_mem_pkg::strobe_events_t events;
  snes_mem_pkg::map_result_t    map;

  logic [snes_mem_pkg::snes_addr_w-1:0] seq_addr;
  logic [snes_mem_pkg::data_w-1:0]      seq_wdata;
  logic seq_we_n;
  logic snes_wr_cycle;
  logic need_snes_addr;
  logic addr0;

  bus_strobe_sync u_sync (
    .CLK2        (CLK2),
    .rst_n       (rst_n),
    .snes_rd_n   (snes_rd_n),
    .snes_wr_n   (snes_wr_n),
    .snes_cpu_clk(snes_cpu_clk),
    .events      (events)
  );

  lorom_mapper #(
    .SAVERAM_BASE(SAVERAM_BASE)
  ) u_mapper (
    .snes_addr   (snes_addr),
    .rom_mask    (rom_mask),
    .saveram_mask(saveram_mask),
    .map         (map)
  );

  psram_sequencer #(
    .RD_WAIT (RD_WAIT),
    .WR_WAIT1(WR_WAIT1),
    .WR_WAIT2(WR_WAIT2),
    .MCU_WAIT(MCU_WAIT)
  ) u_seq (
    .CLK2          (CLK2),
    .rst_n         (rst_n),
    .events        (events),
    .map           (map),
    .mcu           (mcu),
    .psram_rdata   (psram_rdata),
    .addr0         (addr0),
    .snes_wdata    (snes_wdata),
    .mcu_rdy       (mcu_rdy),
    .mcu_rdata     (mcu_rdata),
    .snes_rdata    (snes_rdata),
    .seq_addr      (seq_addr),
    .seq_we_n      (seq_we_n),
    .seq_wdata     (seq_wdata),
    .snes_wr_cycle (snes_wr_cycle),
    .need_snes_addr(need_snes_addr)
  );

  psram_lane_mux u_lane (
    .snes_cpu_clk  (snes_cpu_clk),
    .need_snes_addr(need_snes_addr),
    .map           (map),
    .seq_addr      (seq_addr),
    .seq_we_n      (seq_we_n),
    .seq_wdata     (seq_wdata),
    .snes_wr_cycle (snes_wr_cycle),
    .bus           (psram),
    .addr0         (addr0)
  );

  // Console data bus buffer
  assign snes_data_dir  = ~snes_rd_n;
  assign snes_data_oe_n = (snes_rd_n & snes_wr_n) |
                          (map.is_rom & snes_cs_n) |
                          (~map.is_rom & ~map.is_saveram & ~map.is_writable);

endmodule

// File: hw/psram_lane_mux.sv
`timescale 1ns/1ps

module psram_lane_mux (
  input  logic                                 snes_cpu_clk,
  input  logic                                 need_snes_addr,
  input  snes_mem_pkg::map_result_t            map,
  input  logic [snes_mem_pkg::snes_addr_w-1:0] seq_addr,
  input  logic                                 seq_we_n,
  input  logic [snes_mem_pkg::data_w-1:0]      seq_wdata,
  input  logic                                 snes_wr_cycle,
  output snes_mem_pkg::psram_bus_t             bus,
  output logic                                 addr0
);

  logic assert_snes_addr;
  logic we_n;
  logic [snes_mem_pkg::snes_addr_w-1:0] byte_addr;

  // Console address goes straight out while its clock is high
  assign assert_snes_addr = need_snes_addr & snes_cpu_clk;
  assign byte_addr        = assert_snes_addr ? map.addr : seq_addr;
  assign addr0            = byte_addr[0];

  // No stray writes while a console read owns the bus
  assign we_n = seq_we_n | (assert_snes_addr & ~snes_wr_cycle);

  always_comb begin
    bus.addr     = byte_addr[snes_mem_pkg::snes_addr_w-1:1];
    bus.we_n     = we_n;
    bus.wdata_en = ~we_n;
    bus.bhe_n    = 1'b0;
    bus.ble_n    = 1'b0;
    bus.wdata    = '0;
    if (!we_n) begin
      // Odd byte in the low lane, even byte in the high lane
      bus.bhe_n = addr0;
      bus.ble_n = ~addr0;
      if (addr0) begin
        bus.wdata = {8'h00, seq_wdata};
      end else begin
        bus.wdata = {seq_wdata, 8'h00};
      end
    end
  end

endmodule

// File: hw/psram_sequencer.sv
`timescale 1ns/1ps

module psram_sequencer #(
  parameter int RD_WAIT  = 4,
  parameter int WR_WAIT1 = 2,
  parameter int WR_WAIT2 = 3,
  parameter int MCU_WAIT = 6
) (
  input  logic                                 CLK2,
  input  logic                                 rst_n,
  input  snes_mem_pkg::strobe_events_t         events,
  input  snes_mem_pkg::map_result_t            map,
  input  snes_mem_pkg::mcu_req_t               mcu,
  input  logic [2*snes_mem_pkg::data_w-1:0]    psram_rdata,
  input  logic                                 addr0,
  input  logic [snes_mem_pkg::data_w-1:0]      snes_wdata,
  output logic                                 mcu_rdy,
  output logic [snes_mem_pkg::data_w-1:0]      mcu_rdata,
  output logic [snes_mem_pkg::data_w-1:0]      snes_rdata,
  output logic [snes_mem_pkg::snes_addr_w-1:0] seq_addr,
  output logic                                 seq_we_n,
  output logic [snes_mem_pkg::data_w-1:0]      seq_wdata,
  output logic                                 snes_wr_cycle,
  output logic                                 need_snes_addr
);

  snes_mem_pkg::seq_state_e state;
  logic [3:0] delay;
  logic       delay_done;
  logic       mcu_rd_pend;
  logic       mcu_wr_pend;
  logic       mcu_end;

  logic [snes_mem_pkg::snes_addr_w-1:0] mcu_addr_r;
  logic [snes_mem_pkg::data_w-1:0]      mcu_wdata_r;
  logic [snes_mem_pkg::data_w-1:0]      rd_byte;

  assign delay_done = (delay == 4'h0);
  assign mcu_end    = (state == snes_mem_pkg::ST_MCU_RD_END) ||
                      (state == snes_mem_pkg::ST_MCU_WR_END);

  // Odd byte sits in the low half
  assign rd_byte = addr0 ? psram_rdata[7:0] : psram_rdata[15:8];

  ////////////////////////////////////////
  // Request tracking
  ////////////////////////////////////////

  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      mcu_rd_pend <= 1'b0;
      mcu_wr_pend <= 1'b0;
      mcu_rdy     <= 1'b1;
    end else if (mcu.rrq) begin
      mcu_rd_pend <= 1'b1;
      mcu_rdy     <= 1'b0;
    end else if (mcu.wrq) begin
      mcu_wr_pend <= 1'b1;
      mcu_rdy     <= 1'b0;
    end else if (mcu_end) begin
      mcu_rd_pend <= 1'b0;
      mcu_wr_pend <= 1'b0;
      mcu_rdy     <= 1'b1;
    end
  end

  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      need_snes_addr <= 1'b0;
    end else if (events.cycle_end) begin
      need_snes_addr <= 1'b1;
    end else if ((state == snes_mem_pkg::ST_SNES_RD_END) ||
                 (state == snes_mem_pkg::ST_SNES_WR_END)) begin
      need_snes_addr <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // State machine
  ////////////////////////////////////////

  // Console cycles preempt anything in flight
  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      state         <= snes_mem_pkg::ST_IDLE;
      delay         <= 4'h0;
      seq_we_n      <= 1'b1;
      snes_wr_cycle <= 1'b0;
    end else if (events.wr_start) begin
      state    <= snes_mem_pkg::ST_SNES_WR_ADDR;
      seq_we_n <= 1'b1;
    end else if (events.cycle_start) begin
      state         <= snes_mem_pkg::ST_SNES_RD_ADDR;
      seq_we_n      <= 1'b1;
      snes_wr_cycle <= 1'b0;
    end else begin
      case (state)
        snes_mem_pkg::ST_IDLE: begin
          if (mcu_rd_pend) begin
            state <= snes_mem_pkg::ST_MCU_RD_ADDR;
          end else if (mcu_wr_pend) begin
            state <= snes_mem_pkg::ST_MCU_WR_ADDR;
          end
        end
        snes_mem_pkg::ST_SNES_RD_ADDR: begin
          delay <= 4'(RD_WAIT);
          state <= snes_mem_pkg::ST_SNES_RD_WAIT;
        end
        snes_mem_pkg::ST_SNES_RD_WAIT: begin
          delay <= delay - 4'h1;
          if (delay_done) begin
            state <= snes_mem_pkg::ST_SNES_RD_END;
          end
        end
        snes_mem_pkg::ST_SNES_WR_ADDR: begin
          seq_we_n      <= !map.is_writable;
          snes_wr_cycle <= 1'b1;
          delay         <= 4'(WR_WAIT1);
          state         <= snes_mem_pkg::ST_SNES_WR_WAIT1;
        end
        snes_mem_pkg::ST_SNES_WR_WAIT1: begin
          delay <= delay - 4'h1;
          if (delay_done) begin
            state <= snes_mem_pkg::ST_SNES_WR_DATA;
          end
        end
        snes_mem_pkg::ST_SNES_WR_DATA: begin
          delay <= 4'(WR_WAIT2);
          state <= snes_mem_pkg::ST_SNES_WR_WAIT2;
        end
        snes_mem_pkg::ST_SNES_WR_WAIT2: begin
          delay <= delay - 4'h1;
          if (delay_done) begin
            state <= snes_mem_pkg::ST_SNES_WR_END;
          end
        end
        snes_mem_pkg::ST_SNES_WR_END: begin
          seq_we_n      <= 1'b1;
          snes_wr_cycle <= 1'b0;
          state         <= snes_mem_pkg::ST_IDLE;
        end
        snes_mem_pkg::ST_MCU_RD_ADDR: begin
          delay <= 4'(MCU_WAIT);
          state <= snes_mem_pkg::ST_MCU_RD_WAIT;
        end
        snes_mem_pkg::ST_MCU_RD_WAIT: begin
          delay <= delay - 4'h1;
          if (delay_done) begin
            delay <= 4'h1;
            state <= snes_mem_pkg::ST_MCU_RD_REC;
          end
        end
        snes_mem_pkg::ST_MCU_WR_ADDR: begin
          seq_we_n <= 1'b0;
          delay    <= 4'(MCU_WAIT);
          state    <= snes_mem_pkg::ST_MCU_WR_WAIT;
        end
        snes_mem_pkg::ST_MCU_WR_WAIT: begin
          delay <= delay - 4'h1;
          if (delay_done) begin
            seq_we_n <= 1'b1;
            delay    <= 4'h1;
            state    <= snes_mem_pkg::ST_MCU_WR_REC;
          end
        end
        // Recovery gives a late console cycle time to abort us
        snes_mem_pkg::ST_MCU_RD_REC, snes_mem_pkg::ST_MCU_WR_REC: begin
          delay <= delay - 4'h1;
          if (delay_done) begin
            state <= (state == snes_mem_pkg::ST_MCU_RD_REC) ?
                     snes_mem_pkg::ST_MCU_RD_END : snes_mem_pkg::ST_MCU_WR_END;
          end
        end
        default: begin
          state <= snes_mem_pkg::ST_IDLE;
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // Address and data capture
  ////////////////////////////////////////

  always_ff @(posedge CLK2) begin
    if (mcu.rrq || mcu.wrq) begin
      mcu_addr_r  <= mcu.addr;
      mcu_wdata_r <= mcu.wdata;
    end
    case (state)
      snes_mem_pkg::ST_IDLE,
      snes_mem_pkg::ST_SNES_RD_ADDR,
      snes_mem_pkg::ST_SNES_WR_ADDR: begin
        seq_addr <= map.addr;
      end
      snes_mem_pkg::ST_SNES_RD_WAIT,
      snes_mem_pkg::ST_SNES_RD_END: begin
        snes_rdata <= rd_byte;
      end
      snes_mem_pkg::ST_SNES_WR_DATA: begin
        seq_wdata <= snes_wdata;
      end
      snes_mem_pkg::ST_MCU_RD_ADDR: begin
        seq_addr <= mcu_addr_r;
      end
      snes_mem_pkg::ST_MCU_RD_WAIT: begin
        mcu_rdata <= rd_byte;
      end
      snes_mem_pkg::ST_MCU_WR_ADDR: begin
        seq_addr  <= mcu_addr_r;
        seq_wdata <= mcu_wdata_r;
      end
      default: begin
      end
    endcase
  end

endmodule

// File: hw/lorom_mapper.sv
`timescale 1ns/1ps

module lorom_mapper #(
  parameter logic [snes_mem_pkg::snes_addr_w-1:0] SAVERAM_BASE = 24'hE00000
) (
  input  snes_mem_pkg::snes_addr_u                snes_addr,
  input  logic [snes_mem_pkg::snes_addr_w-1:0]    rom_mask,
  input  logic [snes_mem_pkg::snes_addr_w-1:0]    saveram_mask,
  output snes_mem_pkg::map_result_t               map
);

  logic in_saveram_bank;
  logic [snes_mem_pkg::snes_addr_w-1:0] rom_linear;

  // Banks 70-7D, lower half of each bank
  assign in_saveram_bank = (snes_addr.lorom.bank >= 8'h70) &&
                           (snes_addr.lorom.bank <= 8'h7D) &&
                           !snes_addr.lorom.a15;

  // 32k pages packed back to back
  assign rom_linear = {2'b00, snes_addr.lorom.bank[6:0], snes_addr.lorom.offset};

  always_comb begin
    map = '0;
    if (in_saveram_bank) begin
      map.addr        = SAVERAM_BASE + (snes_addr.flat & saveram_mask);
      map.is_saveram  = 1'b1;
      map.is_writable = 1'b1;
    end else if (snes_addr.lorom.a15) begin
      map.addr   = rom_linear & rom_mask;
      map.is_rom = 1'b1;
    end
  end

endmodule

// File: hw/bus_strobe_sync.sv
`timescale 1ns/1ps

module bus_strobe_sync (
  input  logic                         CLK2,
  input  logic                         rst_n,
  input  logic                         snes_rd_n,
  input  logic                         snes_wr_n,
  input  logic                         snes_cpu_clk,
  output snes_mem_pkg::strobe_events_t events
);

  logic [5:0] rd_hist;
  logic [5:0] wr_hist;
  logic [5:0] clk_hist;

  // Strobes idle high, CPU clock idles low
  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      rd_hist  <= 6'b111111;
      wr_hist  <= 6'b111111;
      clk_hist <= 6'b000000;
    end else begin
      rd_hist  <= {rd_hist[4:0], snes_rd_n};
      wr_hist  <= {wr_hist[4:0], snes_wr_n};
      clk_hist <= {clk_hist[4:0], snes_cpu_clk};
    end
  end

  // Five stable samples then the new level
  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      events <= '0;
    end else begin
      events.rd_start    <= (rd_hist == 6'b111110);
      events.wr_start    <= (wr_hist == 6'b111110);
      events.cycle_start <= (clk_hist == 6'b000001);
      events.cycle_end   <= (clk_hist == 6'b111110);
    end
  end

endmodule

// File: hw/snes_mem_pkg.sv
package snes_mem_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  localparam int snes_addr_w  = 24;
  localparam int psram_addr_w = 23;
  localparam int data_w       = 8;

  ////////////////////////////////////////
  // Console address, flat or LoROM view
  ////////////////////////////////////////

  typedef union packed {
    logic [snes_addr_w-1:0] flat;
    struct packed {
      logic [7:0]  bank;
      logic        a15;
      logic [14:0] offset;
    } lorom;
  } snes_addr_u;

  // Mapped byte address plus region flags
  typedef struct packed {
    logic [snes_addr_w-1:0] addr;
    logic                   is_rom;
    logic                   is_saveram;
    logic                   is_writable;
  } map_result_t;

  typedef struct packed {
    logic rd_start;
    logic wr_start;
    logic cycle_start;
    logic cycle_end;
  } strobe_events_t;

  // Single-byte request from the microcontroller
  typedef struct packed {
    logic                   rrq;
    logic                   wrq;
    logic [snes_addr_w-1:0] addr;
    logic [data_w-1:0]      wdata;
  } mcu_req_t;

  typedef struct packed {
    logic [psram_addr_w-1:0] addr;
    logic                    we_n;
    logic                    bhe_n;
    logic                    ble_n;
    logic [2*data_w-1:0]     wdata;
    logic                    wdata_en;
  } psram_bus_t;

  ////////////////////////////////////////
  // Sequencer states, one-hot
  ////////////////////////////////////////

  typedef enum logic [16:0] {
    ST_IDLE          = 17'h00001,
    ST_SNES_RD_ADDR  = 17'h00002,
    ST_SNES_RD_WAIT  = 17'h00004,
    ST_SNES_RD_END   = 17'h00008,
    ST_SNES_WR_ADDR  = 17'h00010,
    ST_SNES_WR_WAIT1 = 17'h00020,
    ST_SNES_WR_DATA  = 17'h00040,
    ST_SNES_WR_WAIT2 = 17'h00080,
    ST_SNES_WR_END   = 17'h00100,
    ST_MCU_RD_ADDR   = 17'h00200,
    ST_MCU_RD_WAIT   = 17'h00400,
    ST_MCU_RD_REC    = 17'h00800,
    ST_MCU_RD_END    = 17'h01000,
    ST_MCU_WR_ADDR   = 17'h02000,
    ST_MCU_WR_WAIT   = 17'h04000,
    ST_MCU_WR_REC    = 17'h08000,
    ST_MCU_WR_END    = 17'h10000
  } seq_state_e;

endpackage
